//--- all.f
verilog/rv_core_pkg.sv
verilog/rv_fetch.sv
verilog/rv_fetch_queue.sv
verilog/rv_decode.sv
verilog/rv_regfile.sv
verilog/rv_execute.sv
verilog/rv_core_top.sv
tb/tb_rv_core.sv

//--- tb/tb_rv_core.sv
// testbench with clock and reset, random program, imem model, reference model, checker, timeout
`timescale 1ns/1ps
`default_nettype none

module tb_rv_core;
    import rv_core_pkg::*;

    localparam logic [XLEN-1:0] RESET_PC     = '0;
    localparam int              FQ_DEPTH     = 4;
    localparam int              RESET_CYCLES = 5;
    localparam int              N_RETIRE     = 2000;
    localparam int              PIPE_FILL    = 20;  // reset release to first retire plus slack
    // back-to-back redirects cost at most three cycles per retirement
    localparam int              MAX_CYCLES   = N_RETIRE * 3 + RESET_CYCLES + PIPE_FILL;

    // one expected retirement plus where the model goes next
    typedef struct packed {
        logic [XLEN-1:0]       pc;
        logic [REG_ADDR_W-1:0] rd;
        logic                  we;
        logic [XLEN-1:0]       data;
        logic [XLEN-1:0]       next_pc;
    } expect_t;

    logic                  clk_i;
    logic                  rst_n_i;
    logic                  imem_req_o;
    logic [XLEN-1:0]       imem_addr_o;
    logic [INST_W-1:0]     imem_rdata_i;
    logic                  retire_valid_o;
    logic [XLEN-1:0]       retire_pc_o;
    logic [REG_ADDR_W-1:0] retire_rd_o;
    logic                  retire_we_o;
    logic [XLEN-1:0]       retire_data_o;

    logic [INST_W-1:0] imem [256];     // program indexed by addr[9:2]
    logic [XLEN-1:0]   model_regs [32];
    logic [XLEN-1:0]   model_pc;
    logic [31:0]       rng_state;
    int                retired;
    int                cycles;

    rv_core_top #(
        .RESET_PC (RESET_PC),
        .FQ_DEPTH (FQ_DEPTH)
    ) DUT (
        .clk_i          (clk_i),
        .rst_n_i        (rst_n_i),
        .imem_req_o     (imem_req_o),
        .imem_addr_o    (imem_addr_o),
        .imem_rdata_i   (imem_rdata_i),
        .retire_valid_o (retire_valid_o),
        .retire_pc_o    (retire_pc_o),
        .retire_rd_o    (retire_rd_o),
        .retire_we_o    (retire_we_o),
        .retire_data_o  (retire_data_o)
    );

    // ------------------------------------------------------------------
    // random numbers, sign extension and instruction encoders
    // ------------------------------------------------------------------
    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // sign extend the low w bits of v
    function automatic logic [XLEN-1:0] sext(input logic [XLEN-1:0] v, input int w);
        logic [XLEN-1:0] t;
        t = v << (XLEN - w);
        return $signed(t) >>> (XLEN - w);
    endfunction

    function automatic logic [31:0] itype_word(input logic [11:0] imm, input logic [4:0] rs1,
                                               input logic [4:0] rd, input logic [6:0] opc);
        return {imm, rs1, 3'b000, rd, opc};   // funct3 0 for addi and jalr
    endfunction

    function automatic logic [31:0] rtype_word(input logic [6:0] f7, input logic [4:0] rs2,
                                               input logic [4:0] rs1, input logic [4:0] rd);
        return {f7, rs2, rs1, 3'b000, rd, OPC_OP};
    endfunction

    function automatic logic [31:0] btype_word(input logic [12:0] imm, input logic [4:0] rs2,
                                               input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OPC_BRANCH};
    endfunction

    function automatic logic [31:0] jtype_word(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OPC_JAL};
    endfunction

    // compares weighted a little toward signed/unsigned less-than
    function automatic logic [2:0] pick_branch(input logic [2:0] k);
        case (k)
            3'd0:    return F3_BEQ;
            3'd1:    return F3_BNE;
            3'd2:    return F3_BLT;
            3'd3:    return F3_BGE;
            3'd4:    return F3_BLTU;
            3'd5:    return F3_BGEU;
            3'd6:    return F3_BLT;
            default: return F3_BLTU;
        endcase
    endfunction

    // ------------------------------------------------------------------
    // reference model stepping one instruction per call
    // ------------------------------------------------------------------
    function automatic expect_t ref_step(input logic [XLEN-1:0] pc, input logic [31:0] inst,
                                         input logic [XLEN-1:0] a, input logic [XLEN-1:0] b);
        expect_t         e;
        logic [2:0]      f3;
        logic [6:0]      f7;
        logic            taken;
        logic [XLEN-1:0] imm_u;
        f3        = inst[14:12];
        f7        = inst[31:25];
        taken     = 1'b0;
        imm_u     = sext({inst[31:12], 12'b0}, 32);  // rv64 U immediate is sign extended
        e.pc      = pc;
        e.rd      = inst[11:7];
        e.we      = 1'b0;
        e.data    = '0;
        e.next_pc = pc + 64'd4;
        case (inst[6:0])
            OPC_OP_IMM: if (f3 == 3'b000) begin
                e.we   = 1'b1;
                e.data = a + sext(inst[31:20], 12);
            end
            OPC_OP: if (f3 == 3'b000 && f7 == 7'h00) begin
                e.we   = 1'b1;
                e.data = a + b;
            end else if (f3 == 3'b000 && f7 == 7'h20) begin
                e.we   = 1'b1;
                e.data = a - b;
            end
            OPC_LUI: begin
                e.we   = 1'b1;
                e.data = imm_u;
            end
            OPC_AUIPC: begin
                e.we   = 1'b1;
                e.data = pc + imm_u;
            end
            OPC_JAL: begin
                e.we      = 1'b1;
                e.data    = pc + 64'd4;                 // link
                e.next_pc = pc + sext({inst[31], inst[19:12], inst[20], inst[30:21], 1'b0}, 21);
            end
            OPC_JALR: begin
                e.we      = 1'b1;
                e.data    = pc + 64'd4;
                e.next_pc = (a + sext(inst[31:20], 12)) & ~64'd1;
            end
            OPC_BRANCH: begin
                case (f3)
                    F3_BEQ:  taken = (a == b);
                    F3_BNE:  taken = (a != b);
                    F3_BLT:  taken = ($signed(a) < $signed(b));
                    F3_BGE:  taken = ($signed(a) >= $signed(b));
                    F3_BLTU: taken = (a < b);
                    F3_BGEU: taken = (a >= b);
                    default: taken = 1'b0;
                endcase
                if (taken) begin
                    e.next_pc = pc + sext({inst[31], inst[7], inst[30:25], inst[11:8], 1'b0}, 13);
                end
            end
            default: ;  // anything else is a nop
        endcase
        return e;
    endfunction

    // random program with forward control flow only so no short trap loops
    task automatic gen_program();
        logic [31:0] r;
        logic [31:0] r2;
        logic [4:0]  sel;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        int          off;
        for (int w = 0; w < 256; w++) begin
            rng_state = xorshift32(rng_state);
            r         = rng_state;
            rng_state = xorshift32(rng_state);
            r2        = rng_state;
            sel = r[4:0];
            rd  = {2'b00, r[7:5]};   // x0..x7 so results feed later ops
            rs1 = {2'b00, r[10:8]};
            rs2 = {2'b00, r[13:11]};
            off = int'(r2[3:0]) + 1; // 1..16 words ahead
            if (sel < 10)       imem[w] = itype_word(r2[11:0], rs1, rd, OPC_OP_IMM);
            else if (sel < 14)  imem[w] = rtype_word(7'h00, rs2, rs1, rd);
            else if (sel < 16)  imem[w] = rtype_word(7'h20, rs2, rs1, rd);
            else if (sel < 18)  imem[w] = {r2[31:12], rd, OPC_LUI};
            else if (sel < 20)  imem[w] = {r2[31:12], rd, OPC_AUIPC};
            else if (sel < 22)  imem[w] = jtype_word(21'(off * 4), rd);
            else if (sel == 22) imem[w] = itype_word(12'((w + 1 + int'(r2[6:0])) * 4), 5'd0,
                                                     rd, OPC_JALR); // absolute target past itself
            else if (sel < 30)  imem[w] = btype_word(13'(off * 4), rs2, rs1,
                                                     pick_branch(r[16:14]));
            else                imem[w] = itype_word(r2[11:0], rs1, 5'd0, OPC_OP_IMM); // x0
        end
    endtask

    task automatic check_field(input string name, input logic [XLEN-1:0] exp_v,
                               input logic [XLEN-1:0] act_v);
        assert (act_v === exp_v)
        else begin
            $display("FAIL %s at retirement %0d: expected %h, actual %h",
                     name, retired, exp_v, act_v);
            $display("Something failed");
            $fatal(1, "retirement mismatch");
        end
    endtask

    // ------------------------------------------------------------------
    // clock, reset, memory
    // ------------------------------------------------------------------
    initial clk_i = 1'b0;
    always #5 clk_i = ~clk_i;  // 10 ns

    initial begin
        rst_n_i      = 1'b0;
        imem_rdata_i = NOP_INST;
        rng_state    = 32'hc3d4d100;
        retired      = 0;
        cycles       = 0;
        model_pc     = RESET_PC;
        for (int i = 0; i < 32; i++) begin
            model_regs[i] = '0;
        end
        gen_program();
        repeat (RESET_CYCLES) @(posedge clk_i);
        rst_n_i <= 1'b1;
    end

    // one-cycle synchronous read without stall
    always @(posedge clk_i) begin
        if (imem_req_o === 1'b1) begin
            imem_rdata_i <= imem[imem_addr_o[9:2]];  // wraps every 1 KiB
        end
    end

    // ------------------------------------------------------------------
    // compare mid-cycle where retire outputs are settled
    // ------------------------------------------------------------------
    always @(negedge clk_i) begin : compare_retire
        logic [INST_W-1:0] inst;
        expect_t           exp_r;
        // no fetch request and no retirement while reset is held
        if (rst_n_i === 1'b0 && cycles > 0) begin
            check_field("reset_imem_req", '0, XLEN'(imem_req_o));
            check_field("reset_retire_valid", '0, XLEN'(retire_valid_o));
        end
        if (rst_n_i === 1'b1 && retire_valid_o === 1'b1) begin
            inst  = imem[model_pc[9:2]];
            exp_r = ref_step(model_pc, inst, model_regs[inst[19:15]], model_regs[inst[24:20]]);
            check_field("retire_pc", exp_r.pc, retire_pc_o);
            check_field("retire_we", XLEN'(exp_r.we), XLEN'(retire_we_o));
            if (exp_r.we) begin
                check_field("retire_rd", XLEN'(exp_r.rd), XLEN'(retire_rd_o));
                check_field("retire_data", exp_r.data, retire_data_o);
                if (exp_r.rd != '0) begin
                    model_regs[exp_r.rd] = exp_r.data;  // x0 stays zero
                end
            end
            model_pc = exp_r.next_pc;
            retired  = retired + 1;
            if (retired == N_RETIRE) begin
                $display("Everything OK");
                $finish;
            end
        end
    end

    // run limit
    always @(posedge clk_i) begin
        cycles = cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("retirement stalled: %0d of %0d retired after %0d cycles",
                     retired, N_RETIRE, cycles);
            $display("Something failed");
            $fatal(1, "timeout");
        end
    end

endmodule

`default_nettype wire

//--- verilog/rv_core_pkg.sv
// widths, opcode and funct3 constants, alu op enum, pipeline structs
`default_nettype none

package rv_core_pkg;

    // ------------------------------------------------------------------
    // widths
    // ------------------------------------------------------------------
    localparam int XLEN       = 64;
    localparam int REG_ADDR_W = 5;
    localparam int INST_W     = 32;

    // major opcodes, inst[6:0]
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;

    // branch funct3
    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;
    localparam logic [2:0] F3_BLT  = 3'b100;
    localparam logic [2:0] F3_BGE  = 3'b101;
    localparam logic [2:0] F3_BLTU = 3'b110;
    localparam logic [2:0] F3_BGEU = 3'b111;

    localparam logic [INST_W-1:0] NOP_INST = 32'h0000_0013; // addi x0,x0,0

    typedef enum logic [1:0] {
        ALU_ADD   = 2'd0,
        ALU_SUB   = 2'd1,
        ALU_PASS2 = 2'd2, // lui
        ALU_LINK  = 2'd3  // pc + 4 for jal/jalr
    } alu_op_e;

    // ------------------------------------------------------------------
    // pipeline records
    // ------------------------------------------------------------------
    typedef struct packed {
        logic [XLEN-1:0]   pc;
        logic [INST_W-1:0] inst;
    } fetch_entry_t;

    typedef struct packed {
        logic [XLEN-1:0]       pc;
        logic [REG_ADDR_W-1:0] rd;
        logic                  rd_we;
        alu_op_e               alu_op;
        logic [XLEN-1:0]       op1;
        logic [XLEN-1:0]       op2;
        logic                  is_branch;
        logic                  is_jump;
        logic [2:0]            br_funct3;
        logic                  br_eq;
        logic                  br_lt;
        logic                  br_ltu;
        logic [XLEN-1:0]       target;
    } dec_op_t;

    typedef struct packed {
        logic            valid;
        logic [XLEN-1:0] pc;
    } redirect_t;

    typedef struct packed {
        logic                  valid;
        logic [XLEN-1:0]       pc;
        logic [REG_ADDR_W-1:0] rd;
        logic                  we;
        logic [XLEN-1:0]       data;
    } wb_t;

endpackage

`default_nettype wire

//--- verilog/rv_core_top.sv
// core top: fetch, fetch queue, decode, register file, execute
`timescale 1ns/1ps
`default_nettype none

module rv_core_top #(
    parameter logic [rv_core_pkg::XLEN-1:0] RESET_PC = '0,
    parameter int                           FQ_DEPTH = 4
) (
    input  wire logic                               clk_i,
    input  wire logic                               rst_n_i,
    // instruction memory
    output logic                                    imem_req_o,
    output logic [rv_core_pkg::XLEN-1:0]            imem_addr_o,
    input  wire logic [rv_core_pkg::INST_W-1:0]     imem_rdata_i,
    // retire trace
    output logic                                    retire_valid_o,
    output logic [rv_core_pkg::XLEN-1:0]            retire_pc_o,
    output logic [rv_core_pkg::REG_ADDR_W-1:0]      retire_rd_o,
    output logic                                    retire_we_o,
    output logic [rv_core_pkg::XLEN-1:0]            retire_data_o
);
    import rv_core_pkg::*;

    redirect_t                 redirect;
    logic [$clog2(FQ_DEPTH):0] fq_count;
    logic                      push;
    fetch_entry_t              push_entry;
    fetch_entry_t              head;
    logic                      not_empty;
    logic                      pop;
    logic [REG_ADDR_W-1:0]     rs1_addr;
    logic [REG_ADDR_W-1:0]     rs2_addr;
    logic [XLEN-1:0]           rs1_data;
    logic [XLEN-1:0]           rs2_data;
    dec_op_t                   dec_op;
    wb_t                       wb;

    // ------------------------------------------------------------------
    // producer and buffer
    // ------------------------------------------------------------------
    rv_fetch #(
        .RESET_PC (RESET_PC),
        .FQ_DEPTH (FQ_DEPTH)
    ) u_fetch (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .redirect_i   (redirect),
        .fq_count_i   (fq_count),
        .imem_req_o   (imem_req_o),
        .imem_addr_o  (imem_addr_o),
        .imem_rdata_i (imem_rdata_i),
        .push_o       (push),
        .push_entry_o (push_entry)
    );

    rv_fetch_queue #(
        .FQ_DEPTH (FQ_DEPTH)
    ) u_fetch_queue (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .push_i       (push),
        .push_entry_i (push_entry),
        .pop_i        (pop),
        .flush_i      (redirect.valid), // redirect empties the queue
        .head_o       (head),
        .not_empty_o  (not_empty),
        .count_o      (fq_count)
    );

    // ------------------------------------------------------------------
    // consumer
    // ------------------------------------------------------------------
    rv_decode u_decode (
        .entry_i    (head),
        .rs1_addr_o (rs1_addr),
        .rs2_addr_o (rs2_addr),
        .rs1_data_i (rs1_data),
        .rs2_data_i (rs2_data),
        .op_o       (dec_op)
    );

    rv_regfile u_regfile (
        .clk_i      (clk_i),
        .rst_n_i    (rst_n_i),
        .rs1_addr_i (rs1_addr),
        .rs2_addr_i (rs2_addr),
        .rs1_data_o (rs1_data),
        .rs2_data_o (rs2_data),
        .wb_i       (wb)
    );

    rv_execute u_execute (
        .valid_i    (not_empty),
        .op_i       (dec_op),
        .pop_o      (pop),
        .wb_o       (wb),
        .redirect_o (redirect)
    );

    // retire trace straight from the writeback record
    assign retire_valid_o = wb.valid;
    assign retire_pc_o    = wb.pc;
    assign retire_rd_o    = wb.rd;
    assign retire_we_o    = wb.we;
    assign retire_data_o  = wb.data;

endmodule

`default_nettype wire

//--- verilog/rv_decode.sv
// decode: fields, immediates, operand select, branch conditions, targets
`timescale 1ns/1ps
`default_nettype none

module rv_decode (
    input  wire rv_core_pkg::fetch_entry_t          entry_i,
    output logic [rv_core_pkg::REG_ADDR_W-1:0]      rs1_addr_o,
    output logic [rv_core_pkg::REG_ADDR_W-1:0]      rs2_addr_o,
    input  wire logic [rv_core_pkg::XLEN-1:0]       rs1_data_i,
    input  wire logic [rv_core_pkg::XLEN-1:0]       rs2_data_i,
    output rv_core_pkg::dec_op_t                    op_o
);
    import rv_core_pkg::*;

    logic [INST_W-1:0] inst;
    logic [6:0]        opcode;
    logic [2:0]        funct3;
    logic [6:0]        funct7;
    logic [XLEN-1:0]   imm_i;
    logic [XLEN-1:0]   imm_b;
    logic [XLEN-1:0]   imm_u;
    logic [XLEN-1:0]   imm_j;

    // ------------------------------------------------------------------
    // field extraction
    // ------------------------------------------------------------------
    assign inst       = entry_i.inst;
    assign opcode     = inst[6:0];
    assign funct3     = inst[14:12];
    assign funct7     = inst[31:25];
    assign rs1_addr_o = inst[19:15];
    assign rs2_addr_o = inst[24:20];

    // sign extended immediates
    assign imm_i = {{52{inst[31]}}, inst[31:20]};
    assign imm_b = {{51{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
    assign imm_u = {{32{inst[31]}}, inst[31:12], 12'b0};        // rv64 sign extends U
    assign imm_j = {{43{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

    // ------------------------------------------------------------------
    // operands, conditions, targets
    // ------------------------------------------------------------------
    always_comb begin
        op_o           = '0;
        op_o.pc        = entry_i.pc;
        op_o.rd        = inst[11:7];
        op_o.alu_op    = ALU_ADD;
        op_o.op1       = rs1_data_i;  // default operand 1
        op_o.op2       = rs2_data_i;  // default operand 2
        op_o.br_funct3 = funct3;
        op_o.br_eq     = (rs1_data_i == rs2_data_i);
        op_o.br_lt     = ($signed(rs1_data_i) < $signed(rs2_data_i));
        op_o.br_ltu    = (rs1_data_i < rs2_data_i);
        op_o.target    = entry_i.pc + imm_b;

        case (opcode)
            OPC_OP_IMM: begin
                if (funct3 == 3'b000) begin // addi only
                    op_o.rd_we = 1'b1;
                    op_o.op2   = imm_i;
                end
            end
            OPC_OP: begin
                if (funct3 == 3'b000 && funct7 == 7'b0000000) begin
                    op_o.rd_we = 1'b1;                         // add
                end else if (funct3 == 3'b000 && funct7 == 7'b0100000) begin
                    op_o.rd_we  = 1'b1;                        // sub
                    op_o.alu_op = ALU_SUB;
                end
            end
            OPC_LUI: begin
                op_o.rd_we  = 1'b1;
                op_o.alu_op = ALU_PASS2;
                op_o.op2    = imm_u;
            end
            OPC_AUIPC: begin
                op_o.rd_we = 1'b1;
                op_o.op1   = entry_i.pc;
                op_o.op2   = imm_u;
            end
            OPC_JAL: begin
                op_o.rd_we   = 1'b1;
                op_o.alu_op  = ALU_LINK;
                op_o.is_jump = 1'b1;
                op_o.target  = entry_i.pc + imm_j;
            end
            OPC_JALR: begin
                op_o.rd_we   = 1'b1;
                op_o.alu_op  = ALU_LINK;
                op_o.is_jump = 1'b1;
                op_o.target  = (rs1_data_i + imm_i) & ~XLEN'(1); // clear bit 0
            end
            OPC_BRANCH: begin
                op_o.is_branch = 1'b1; // target already pc + imm_b
            end
            default: ;                 // unsupported, retires as nop
        endcase
    end

endmodule

`default_nettype wire

//--- verilog/rv_execute.sv
// execute: alu, branch resolution, writeback record, redirect
`timescale 1ns/1ps
`default_nettype none

module rv_execute (
    input  wire logic                  valid_i,
    input  wire rv_core_pkg::dec_op_t  op_i,
    output logic                       pop_o,
    output rv_core_pkg::wb_t           wb_o,
    output rv_core_pkg::redirect_t     redirect_o
);
    import rv_core_pkg::*;

    logic [XLEN-1:0] alu_res;
    logic            br_taken;

    // ------------------------------------------------------------------
    // alu
    // ------------------------------------------------------------------
    always_comb begin
        case (op_i.alu_op)
            ALU_ADD:   alu_res = op_i.op1 + op_i.op2;
            ALU_SUB:   alu_res = op_i.op1 - op_i.op2;
            ALU_PASS2: alu_res = op_i.op2;              // lui
            ALU_LINK:  alu_res = op_i.pc + XLEN'(4);    // return address
            default:   alu_res = '0;
        endcase
    end

    // branch condition from funct3
    always_comb begin
        case (op_i.br_funct3)
            F3_BEQ:  br_taken = op_i.br_eq;
            F3_BNE:  br_taken = ~op_i.br_eq;
            F3_BLT:  br_taken = op_i.br_lt;
            F3_BGE:  br_taken = ~op_i.br_lt;
            F3_BLTU: br_taken = op_i.br_ltu;
            F3_BGEU: br_taken = ~op_i.br_ltu;
            default: br_taken = 1'b0; // reserved encodings fall through
        endcase
    end

    // ------------------------------------------------------------------
    // retire
    // ------------------------------------------------------------------
    assign pop_o = valid_i; // one retire per cycle while queue has data

    assign wb_o.valid = valid_i;
    assign wb_o.pc    = op_i.pc;
    assign wb_o.rd    = op_i.rd;
    assign wb_o.we    = op_i.rd_we;
    assign wb_o.data  = alu_res;

    // taken branch or any jump flushes the queue and restarts fetch
    assign redirect_o.valid = valid_i & (op_i.is_jump | (op_i.is_branch & br_taken));
    assign redirect_o.pc    = op_i.target;

endmodule

`default_nettype wire

//--- verilog/rv_fetch.sv
// fetch unit with pc, memory request, credit check against the queue and redirect
`timescale 1ns/1ps
`default_nettype none

module rv_fetch #(
    parameter logic [rv_core_pkg::XLEN-1:0] RESET_PC = '0,
    parameter int                           FQ_DEPTH = 4
) (
    input  wire logic                               clk_i,
    input  wire logic                               rst_n_i,
    input  wire rv_core_pkg::redirect_t             redirect_i,
    input  wire logic [$clog2(FQ_DEPTH):0]          fq_count_i,
    output logic                                    imem_req_o,
    output logic [rv_core_pkg::XLEN-1:0]            imem_addr_o,
    input  wire logic [rv_core_pkg::INST_W-1:0]     imem_rdata_i,
    output logic                                    push_o,
    output rv_core_pkg::fetch_entry_t               push_entry_o
);
    import rv_core_pkg::*;

    localparam int CNT_W = $clog2(FQ_DEPTH) + 1;

    logic [XLEN-1:0] pc_q;          // next pc to request
    logic [XLEN-1:0] inflight_pc_q; // pc of the request answered this cycle
    logic            inflight_q;    // response arrives this cycle
    logic            fetch_en_q;    // low straight after reset
    logic [CNT_W:0]  credits_used;
    logic            credit_ok;

    // queued entries plus the one still on its way from memory
    assign credits_used = {1'b0, fq_count_i} + {{CNT_W{1'b0}}, inflight_q};
    assign credit_ok    = credits_used < (CNT_W+1)'(FQ_DEPTH);

    assign imem_req_o  = fetch_en_q & credit_ok;
    assign imem_addr_o = pc_q;

    // response becomes a queue entry unless the queue is flushed
    assign push_o            = inflight_q & ~redirect_i.valid;
    assign push_entry_o.pc   = inflight_pc_q;
    assign push_entry_o.inst = imem_rdata_i;

    // ------------------------------------------------------------------
    // pc and outstanding request
    // ------------------------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            pc_q       <= RESET_PC;
            inflight_q <= 1'b0;
            fetch_en_q <= 1'b0;
        end else begin
            fetch_en_q <= 1'b1;
            if (redirect_i.valid) begin
                pc_q       <= redirect_i.pc; // restart at target
                inflight_q <= 1'b0;          // cancel wrong-path response
            end else begin
                inflight_q <= imem_req_o;
                if (imem_req_o) begin
                    pc_q <= pc_q + XLEN'(4);
                end
            end
        end
    end

    // pc of the request now in flight
    always_ff @(posedge clk_i) begin
        if (imem_req_o) begin
            inflight_pc_q <= pc_q;
        end
    end

endmodule

`default_nettype wire

//--- verilog/rv_fetch_queue.sv
// fetch queue: circular buffer with count, push, pop and flush
`timescale 1ns/1ps
`default_nettype none

module rv_fetch_queue #(
    parameter int FQ_DEPTH = 4
) (
    input  wire logic                        clk_i,
    input  wire logic                        rst_n_i,
    input  wire logic                        push_i,
    input  wire rv_core_pkg::fetch_entry_t   push_entry_i,
    input  wire logic                        pop_i,
    input  wire logic                        flush_i,
    output rv_core_pkg::fetch_entry_t        head_o,
    output logic                             not_empty_o,
    output logic [$clog2(FQ_DEPTH):0]        count_o
);
    import rv_core_pkg::*;

    localparam int PTR_W = $clog2(FQ_DEPTH);

    fetch_entry_t     mem_q [FQ_DEPTH];
    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] rd_ptr_q;
    logic [PTR_W:0]   count_q;
    logic             do_push;
    logic             do_pop;

    assign do_push = push_i & ~flush_i;
    assign do_pop  = pop_i & not_empty_o & ~flush_i;

    assign not_empty_o = (count_q != '0);
    assign count_o     = count_q;

    // empty queue shows a nop so decode never sees stale data
    assign head_o = not_empty_o ? mem_q[rd_ptr_q]
                                : fetch_entry_t'{pc: '0, inst: NOP_INST};

    // wrap at FQ_DEPTH, depth need not be a power of two
    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
        return (p == PTR_W'(FQ_DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    // ------------------------------------------------------------------
    // pointers and count
    // ------------------------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (!rst_n_i || flush_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr_q <= ptr_inc(wr_ptr_q);
            end
            if (do_pop) begin
                rd_ptr_q <= ptr_inc(rd_ptr_q);
            end
            case ({do_push, do_pop})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q; // both or neither
            endcase
        end
    end

    // storage
    always_ff @(posedge clk_i) begin
        if (do_push) begin
            mem_q[wr_ptr_q] <= push_entry_i;
        end
    end

endmodule

`default_nettype wire

//--- verilog/rv_regfile.sv
// register file: 32 x 64, two read ports, one write port, x0 reads zero
`timescale 1ns/1ps
`default_nettype none

module rv_regfile (
    input  wire logic                               clk_i,
    input  wire logic                               rst_n_i,
    input  wire logic [rv_core_pkg::REG_ADDR_W-1:0] rs1_addr_i,
    input  wire logic [rv_core_pkg::REG_ADDR_W-1:0] rs2_addr_i,
    output logic [rv_core_pkg::XLEN-1:0]            rs1_data_o,
    output logic [rv_core_pkg::XLEN-1:0]            rs2_data_o,
    input  wire rv_core_pkg::wb_t                   wb_i
);
    import rv_core_pkg::*;

    logic [XLEN-1:0] regs_q [1:31]; // x0 has no storage
    logic            wr_en;

    assign wr_en = wb_i.valid & wb_i.we & (wb_i.rd != '0);

    // combinational reads
    assign rs1_data_o = (rs1_addr_i == '0) ? '0 : regs_q[rs1_addr_i];
    assign rs2_data_o = (rs2_addr_i == '0) ? '0 : regs_q[rs2_addr_i];

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            for (int i = 1; i < 32; i++) begin
                regs_q[i] <= '0;
            end
        end else if (wr_en) begin
            regs_q[wb_i.rd] <= wb_i.data;
        end
    end

endmodule

`default_nettype wire
